// ==== Makefile ====
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing -Wno-fatal
TOP       ?= tb_cps_readout
FLIST     ?= cps_readout.f
LOG       ?= sim.log

SRCS := $(filter %.sv,$(shell cat $(FLIST))) cps_defines.svh
BIN  := obj_dir/V$(TOP)

.PHONY: all run clean

all: run

$(BIN): $(SRCS) $(FLIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FLIST)

run: $(BIN)
	./$(BIN) | tee $(LOG)
	grep -q "Simulation passed" $(LOG)

clean:
	rm -rf obj_dir $(LOG)

// ==== cps_defines.svh ====
`ifndef CPS_DEFINES_SVH
`define CPS_DEFINES_SVH

// ADC beat shape
`define ADC_CHANNELS    16      // Channels per beat
`define SAMPLE_W        16
`define WORD_W          32      // FIFO and bus word
`define WORDS_PER_BEAT  8       // Two samples per word
`define COLS_PER_ROW    16      // Beats per row
`define ROW_W           6
`define COL_W           4

// Event FIFO
`define FIFO_DEPTH      64
`define FIFO_LVL_W      7       // Holds 0 to FIFO_DEPTH
`define FIFO_PROG_FULL  48

`define VETO_CYCLES     450     // Write blackout after reset

// Wishbone register map
`define WB_ADR_W        3
`define REG_CMD         3'd0    // Write only
`define REG_ROW_START   3'd1
`define REG_ROW_END     3'd2
`define REG_COL_START   3'd3
`define REG_COL_END     3'd4
`define REG_STATUS      3'd5    // Read only
`define REG_DATA        3'd6    // Read pops the FIFO

`endif

// ==== cps_pkg.sv ====
`include "cps_defines.svh"

package cps_pkg;

  // Run FSM states
  typedef enum logic [1:0] {
    R_IDLE,
    R_READY,
    R_RUNNING,
    R_STOPPING
  } run_state_e;

  // Host command opcodes, written to REG_CMD
  typedef enum logic [1:0] {
    CMD_NONE  = 2'd0,
    CMD_INIT  = 2'd1,
    CMD_START = 2'd2,
    CMD_STOP  = 2'd3
  } cmd_opcode_e;

  typedef struct packed {
    logic [`ROW_W-1:0] row_start;
    logic [`ROW_W-1:0] row_end;
    logic [`COL_W-1:0] col_start;
    logic [`COL_W-1:0] col_end;
  } readout_window_t;  // All bounds inclusive

  // Channel 0 sits in the low bits
  typedef logic [`ADC_CHANNELS-1:0][`SAMPLE_W-1:0] adc_beat_t;

  typedef struct packed {
    logic                cyc;
    logic                stb;
    logic                we;
    logic [`WB_ADR_W-1:0] adr;
    logic [`WORD_W-1:0]  dat;
  } wb_req_t;

  typedef struct packed {
    logic               ack;
    logic               err;
    logic [`WORD_W-1:0] dat;
  } wb_rsp_t;

endpackage

// ==== cps_readout.f ====
+incdir+.
cps_pkg.sv
event_fifo.sv
host_cmd_regs.sv
run_control.sv
frame_packer.sv
cps_readout_top.sv
tb_cps_readout.sv

// ==== cps_readout_top.sv ====
`timescale 1ns/1ps
`include "cps_defines.svh"

module cps_readout_top (
  input  logic               clk100M,
  input  logic               rst_command,
  input  cps_pkg::wb_req_t   wb_req,
  output cps_pkg::wb_rsp_t   wb_rsp,
  input  logic               beat_valid,
  output logic               beat_ready,
  input  cps_pkg::adc_beat_t beat_data,
  input  logic               frame_start
);
  import cps_pkg::*;

  cmd_opcode_e            cmd;         // One-cycle command pulse
  readout_window_t        window;      // Active after INIT
  run_state_e             run_state;
  logic                   veto;
  logic                   capture_en;
  logic                   prog_full;
  logic                   frame_done;
  logic                   fifo_wr;
  logic [`WORD_W-1:0]     fifo_wdata;
  logic                   fifo_rd;
  logic [`WORD_W-1:0]     fifo_rdata;
  logic                   fifo_empty;
  logic [`FIFO_LVL_W-1:0] fifo_level;

  host_cmd_regs u_regs (
    .clk100M     (clk100M),
    .rst_command (rst_command),
    .wb_req      (wb_req),
    .wb_rsp      (wb_rsp),
    .cmd         (cmd),
    .window      (window),
    .run_state   (run_state),
    .veto        (veto),
    .prog_full   (prog_full),
    .fifo_level  (fifo_level),
    .frame_done  (frame_done),
    .fifo_rd     (fifo_rd),
    .fifo_rdata  (fifo_rdata),
    .fifo_empty  (fifo_empty)
  );

  run_control u_run (
    .clk100M     (clk100M),
    .rst_command (rst_command),
    .cmd         (cmd),
    .frame_done  (frame_done),
    .prog_full   (prog_full),
    .run_state   (run_state),
    .veto        (veto),
    .capture_en  (capture_en)
  );

  frame_packer u_packer (
    .clk100M     (clk100M),
    .rst_command (rst_command),
    .beat_valid  (beat_valid),
    .beat_ready  (beat_ready),
    .beat_data   (beat_data),
    .frame_start (frame_start),
    .window      (window),
    .capture_en  (capture_en),
    .fifo_wr     (fifo_wr),
    .fifo_wdata  (fifo_wdata),
    .frame_done  (frame_done)
  );

  event_fifo u_fifo (
    .clk100M     (clk100M),
    .rst_command (rst_command),
    .wr          (fifo_wr),
    .wdata       (fifo_wdata),
    .rd          (fifo_rd),
    .rdata       (fifo_rdata),
    .empty       (fifo_empty),
    .full        (),             // prog_full throttles well before full
    .level       (fifo_level),
    .prog_full   (prog_full)
  );

endmodule

// ==== event_fifo.sv ====
`timescale 1ns/1ps
`include "cps_defines.svh"

module event_fifo (
  input  logic                   clk100M,
  input  logic                   rst_command,
  input  logic                   wr,
  input  logic [`WORD_W-1:0]     wdata,
  input  logic                   rd,
  output logic [`WORD_W-1:0]     rdata,
  output logic                   empty,
  output logic                   full,
  output logic [`FIFO_LVL_W-1:0] level,
  output logic                   prog_full
);

  localparam int AW = $clog2(`FIFO_DEPTH);

  logic [`WORD_W-1:0]     mem [`FIFO_DEPTH];
  logic [`FIFO_LVL_W-1:0] wr_ptr;  // One extra bit over the address
  logic [`FIFO_LVL_W-1:0] rd_ptr;
  logic                   do_wr;
  logic                   do_rd;

  assign do_wr = wr && !full;   // Writes into a full FIFO are lost
  assign do_rd = rd && !empty;

  always_ff @(posedge clk100M) begin
    if (rst_command) begin
      wr_ptr <= '0;
      rd_ptr <= '0;
    end else begin
      if (do_wr)
        wr_ptr <= wr_ptr + 1'b1;
      if (do_rd)
        rd_ptr <= rd_ptr + 1'b1;
    end
  end

  always_ff @(posedge clk100M) begin
    if (do_wr)
      mem[wr_ptr[AW-1:0]] <= wdata;
  end

  // Head word shows without a read strobe
  assign rdata = mem[rd_ptr[AW-1:0]];

  assign level     = wr_ptr - rd_ptr;
  assign empty     = (level == '0);
  assign full      = (level == `FIFO_LVL_W'(`FIFO_DEPTH));
  assign prog_full = (level >= `FIFO_LVL_W'(`FIFO_PROG_FULL));

endmodule

// ==== frame_packer.sv ====
`timescale 1ns/1ps
`include "cps_defines.svh"

module frame_packer (
  input  logic                     clk100M,
  input  logic                     rst_command,
  input  logic                     beat_valid,
  output logic                     beat_ready,
  input  cps_pkg::adc_beat_t       beat_data,
  input  logic                     frame_start,
  input  cps_pkg::readout_window_t window,
  input  logic                     capture_en,
  output logic                     fifo_wr,
  output logic [`WORD_W-1:0]       fifo_wdata,
  output logic                     frame_done
);
  import cps_pkg::*;

  localparam int            IW       = $clog2(`WORDS_PER_BEAT);
  localparam logic [IW-1:0] LAST_IDX = IW'(`WORDS_PER_BEAT - 1);

  logic [`ROW_W-1:0] row;
  logic [`COL_W-1:0] col;
  logic              accept;
  logic              in_win;
  logic              keep;
  logic              at_end;      // Beat sits on the window's last corner
  adc_beat_t         hold_data;
  logic              hold_valid;
  logic              hold_last;
  adc_beat_t         ser_data;
  logic              ser_busy;
  logic              ser_last;
  logic              ser_free;
  logic [IW-1:0]     ser_idx;     // Word being emitted
  logic              end_pend;    // Frame end beat still in flight

  assign accept = beat_valid && beat_ready;
  assign in_win = (row >= window.row_start) && (row <= window.row_end) &&
                  (col >= window.col_start) && (col <= window.col_end);
  assign keep   = accept && in_win && capture_en;  // Whole beat or nothing
  assign at_end = (row == window.row_end) && (col == window.col_end);

  // Stall past the frame end so the FSM sees frame_done first
  assign beat_ready = !hold_valid && !end_pend;

  always_ff @(posedge clk100M) begin
    if (rst_command || frame_start) begin
      row <= '0;
      col <= '0;
    end else if (accept) begin
      if (col == `COL_W'(`COLS_PER_ROW - 1)) begin
        col <= '0;
        row <= row + 1'b1;            // Next row
      end else begin
        col <= col + 1'b1;
      end
    end
  end

  assign ser_free = !ser_busy || (ser_idx == LAST_IDX);  // Can load this edge

  always_ff @(posedge clk100M) begin
    if (rst_command) begin
      ser_busy   <= 1'b0;
      ser_idx    <= '0;
      hold_valid <= 1'b0;
      end_pend   <= 1'b0;
    end else begin
      if (ser_free) begin
        ser_idx  <= '0;
        ser_busy <= hold_valid || keep;  // Held beat goes first
      end else begin
        ser_idx  <= ser_idx + 1'b1;
      end
      if (ser_free && hold_valid)
        hold_valid <= 1'b0;
      else if (!ser_free && keep)
        hold_valid <= 1'b1;              // Park while serializer busy
      if (keep && at_end)
        end_pend <= 1'b1;
      else if (frame_done)
        end_pend <= 1'b0;
    end
  end

  // Beat payload
  always_ff @(posedge clk100M) begin
    if (ser_free && (hold_valid || keep)) begin
      ser_data <= hold_valid ? hold_data : beat_data;
      ser_last <= hold_valid ? hold_last : at_end;
    end
    if (!ser_free && keep) begin
      hold_data <= beat_data;
      hold_last <= at_end;
    end
  end

  assign fifo_wr    = ser_busy;
  assign fifo_wdata = {ser_data[{ser_idx, 1'b1}], ser_data[{ser_idx, 1'b0}]};  // Even ch low
  assign frame_done = ser_busy && (ser_idx == LAST_IDX) && ser_last;

endmodule

// ==== host_cmd_regs.sv ====
`timescale 1ns/1ps
`include "cps_defines.svh"

module host_cmd_regs (
  input  logic                     clk100M,
  input  logic                     rst_command,
  input  cps_pkg::wb_req_t         wb_req,
  output cps_pkg::wb_rsp_t         wb_rsp,
  output cps_pkg::cmd_opcode_e     cmd,
  output cps_pkg::readout_window_t window,
  input  cps_pkg::run_state_e      run_state,
  input  logic                     veto,
  input  logic                     prog_full,
  input  logic [`FIFO_LVL_W-1:0]   fifo_level,
  input  logic                     frame_done,
  output logic                     fifo_rd,
  input  logic [`WORD_W-1:0]       fifo_rdata,
  input  logic                     fifo_empty
);
  import cps_pkg::*;

  readout_window_t    pend_win;   // Staged until next INIT
  cmd_opcode_e        cmd_q;      // Opcode waiting one cycle for its pulse
  logic               ack_q;
  logic               err_q;
  logic [`WORD_W-1:0] rdat_q;
  logic [7:0]         frame_cnt;  // Wraps
  logic               req;
  logic               wr_en;
  logic               rd_data;
  logic [`WORD_W-1:0] status;
  logic [`WORD_W-1:0] rd_mux;

  // A request is new until it has been answered once
  assign req     = wb_req.cyc && wb_req.stb && !ack_q && !err_q;
  assign wr_en   = req && wb_req.we;
  assign rd_data = req && !wb_req.we && (wb_req.adr == `REG_DATA);
  assign fifo_rd = rd_data && !fifo_empty;  // Empty read pops nothing

  assign status = {8'h00, frame_cnt, 8'(fifo_level), 4'h0, prog_full, veto, run_state};

  always_comb begin
    case (wb_req.adr)
      `REG_ROW_START: rd_mux = `WORD_W'(pend_win.row_start);
      `REG_ROW_END:   rd_mux = `WORD_W'(pend_win.row_end);
      `REG_COL_START: rd_mux = `WORD_W'(pend_win.col_start);
      `REG_COL_END:   rd_mux = `WORD_W'(pend_win.col_end);
      `REG_STATUS:    rd_mux = status;
      `REG_DATA:      rd_mux = fifo_rdata;  // Show-ahead head word
      default:        rd_mux = '0;          // CMD reads back zero
    endcase
  end

  always_ff @(posedge clk100M) begin
    if (rst_command) begin
      ack_q     <= 1'b0;
      err_q     <= 1'b0;
      cmd_q     <= CMD_NONE;
      cmd       <= CMD_NONE;
      pend_win  <= '0;
      window    <= '0;
      frame_cnt <= '0;
    end else begin
      ack_q <= req && !(rd_data && fifo_empty);
      err_q <= rd_data && fifo_empty;       // Nothing to hand out
      cmd_q <= (wr_en && wb_req.adr == `REG_CMD) ? cmd_opcode_e'(wb_req.dat[1:0]) : CMD_NONE;
      cmd   <= cmd_q;                       // Pulse lands the cycle after ack
      if (wr_en) begin
        case (wb_req.adr)
          `REG_ROW_START: pend_win.row_start <= wb_req.dat[`ROW_W-1:0];
          `REG_ROW_END:   pend_win.row_end   <= wb_req.dat[`ROW_W-1:0];
          `REG_COL_START: pend_win.col_start <= wb_req.dat[`COL_W-1:0];
          `REG_COL_END:   pend_win.col_end   <= wb_req.dat[`COL_W-1:0];
          default: ;                        // Status and data ignore writes
        endcase
      end
      if (cmd == CMD_INIT)
        window <= pend_win;                 // Same edge the FSM sees INIT
      if (frame_done)
        frame_cnt <= frame_cnt + 8'd1;
    end
  end

  // Read data captured with the answer
  always_ff @(posedge clk100M) begin
    if (req)
      rdat_q <= rd_mux;
  end

  assign wb_rsp = '{ack: ack_q, err: err_q, dat: rdat_q};

endmodule

// ==== run_control.sv ====
`timescale 1ns/1ps
`include "cps_defines.svh"

module run_control (
  input  logic                 clk100M,
  input  logic                 rst_command,
  input  cps_pkg::cmd_opcode_e cmd,
  input  logic                 frame_done,
  input  logic                 prog_full,
  output cps_pkg::run_state_e  run_state,
  output logic                 veto,
  output logic                 capture_en
);
  import cps_pkg::*;

  localparam int VW = $clog2(`VETO_CYCLES + 1);

  logic [VW-1:0] veto_cnt;  // Counts up once, then parks
  logic          run_phase;

  always_ff @(posedge clk100M) begin
    if (rst_command) begin
      run_state <= R_IDLE;
    end else begin
      case (run_state)
        R_IDLE: begin
          if (cmd == CMD_INIT)
            run_state <= R_READY;
        end
        R_READY: begin
          if (cmd == CMD_START)
            run_state <= R_RUNNING;   // INIT again keeps READY
        end
        R_RUNNING: begin
          if (cmd == CMD_STOP)
            run_state <= R_STOPPING;
        end
        R_STOPPING: begin
          if (frame_done)
            run_state <= R_READY;     // Finish the frame in progress
        end
        default: run_state <= R_IDLE;
      endcase
    end
  end

  // Post-reset blackout
  always_ff @(posedge clk100M) begin
    if (rst_command)
      veto_cnt <= '0;
    else if (veto)
      veto_cnt <= veto_cnt + 1'b1;
  end

  assign veto = (veto_cnt != VW'(`VETO_CYCLES));

  assign run_phase  = (run_state == R_RUNNING) || (run_state == R_STOPPING);
  assign capture_en = run_phase && !veto && !prog_full;  // FIFO throttles the gate

endmodule

// ==== tb_cps_readout.sv ====
`timescale 1ns/1ps
`include "cps_defines.svh"

module tb_cps_readout;
  import cps_pkg::*;

  localparam int ROWS   = 4;    // Rows sent per frame
  localparam int FRAMES = 9;
  localparam int WATCH_CYCLES = FRAMES * ROWS * `COLS_PER_ROW * 10 + `VETO_CYCLES + 5000;

  logic      clk100M = 1'b0;
  logic      rst_command;
  wb_req_t   wb_req;
  wb_rsp_t   wb_rsp;
  logic      beat_valid;
  logic      beat_ready;
  adc_beat_t beat_data;
  logic      frame_start;

  logic [31:0]     rng;
  adc_beat_t       exp_q[$];    // Beats the window rule keeps
  readout_window_t ref_win;     // Window the DUT should be using
  int              errors;
  int              checks;

  cps_readout_top dut (
    .clk100M     (clk100M),
    .rst_command (rst_command),
    .wb_req      (wb_req),
    .wb_rsp      (wb_rsp),
    .beat_valid  (beat_valid),
    .beat_ready  (beat_ready),
    .beat_data   (beat_data),
    .frame_start (frame_start)
  );

  always #5 clk100M = ~clk100M;

  function automatic logic [31:0] xorshift(input logic [31:0] s);
    s = s ^ (s << 13);
    s = s ^ (s >> 17);
    s = s ^ (s << 5);
    return s;
  endfunction

  // Even channel in the low half, pair 0/1 first
  function automatic logic [7:0][31:0] expand_beat(input adc_beat_t b);
    logic [7:0][31:0] w;
    for (int i = 0; i < 8; i++)
      w[i] = {b[2*i+1], b[2*i]};
    return w;
  endfunction

  function automatic bit in_window(input int r, input int c);
    return r >= ref_win.row_start && r <= ref_win.row_end &&
           c >= ref_win.col_start && c <= ref_win.col_end;
  endfunction

  task automatic expect_val(input string name, input int got, input int exp);
    checks++;
    if (got != exp) begin
      errors++;
      $display("ERROR at %0t ns: %s got %0d expected %0d", $time, name, got, exp);
    end
  endtask

  task automatic wb_xfer(input bit we, input logic [2:0] adr, input logic [31:0] wdat,
                         output wb_rsp_t rsp);
    @(posedge clk100M);
    wb_req <= '{cyc: 1'b1, stb: 1'b1, we: we, adr: adr, dat: wdat};
    @(posedge clk100M);
    while (!(wb_rsp.ack || wb_rsp.err))
      @(posedge clk100M);
    rsp = wb_rsp;
    wb_req <= '0;                      // Drop stb for a cycle at least
  endtask

  task automatic wb_write(input logic [2:0] adr, input logic [31:0] wdat);
    wb_rsp_t r;
    wb_xfer(1'b1, adr, wdat, r);
    repeat (3) @(posedge clk100M);    // Let the command pulse land
  endtask

  task automatic read_status(output logic [31:0] st);
    wb_rsp_t r;
    wb_xfer(1'b0, `REG_STATUS, 32'h0, r);
    st = r.dat;
  endtask

  task automatic set_window(input readout_window_t w);
    wb_write(`REG_ROW_START, 32'(w.row_start));
    wb_write(`REG_ROW_END,   32'(w.row_end));
    wb_write(`REG_COL_START, 32'(w.col_start));
    wb_write(`REG_COL_END,   32'(w.col_end));
  endtask

  // One frame of ROWS rows, beats from the xorshift stream
  task automatic send_frame(input bit keep_en);
    adc_beat_t b;
    @(posedge clk100M);
    frame_start <= 1'b1;
    @(posedge clk100M);
    frame_start <= 1'b0;
    for (int r = 0; r < ROWS; r++) begin
      for (int c = 0; c < `COLS_PER_ROW; c++) begin
        for (int ch = 0; ch < `ADC_CHANNELS; ch++) begin
          rng   = xorshift(rng);
          b[ch] = rng[15:0];
        end
        beat_valid <= 1'b1;
        beat_data  <= b;
        @(posedge clk100M);
        while (!beat_ready)
          @(posedge clk100M);
        if (keep_en && in_window(r, c))
          exp_q.push_back(b);
      end
    end
    beat_valid <= 1'b0;
  endtask

  // Strict mode takes the queue head; drop mode skips to the next match
  task automatic check_group(input logic [7:0][31:0] grp, input bit allow_drop);
    logic [7:0][31:0] e;
    bit               found;
    found = 1'b0;
    while (!found && exp_q.size() > 0) begin
      e = expand_beat(exp_q.pop_front());
      if (grp == e || !allow_drop)
        found = 1'b1;
    end
    checks++;
    if (!found) begin
      errors++;
      $display("ERROR at %0t ns: a beat was read that matches no expected beat", $time);
    end else begin
      for (int i = 0; i < 8; i++)
        if (grp[i] !== e[i]) begin
          errors++;
          $display("ERROR at %0t ns: fifo_rdata word %0d got %h expected %h",
                   $time, i, grp[i], e[i]);
        end
    end
  endtask

  // Reads REG_DATA while the status level is nonzero
  task automatic drain(input bit allow_drop);
    logic [31:0]      st;
    logic [7:0][31:0] grp;
    wb_rsp_t          r;
    int               n;
    n = 0;
    repeat (30) @(posedge clk100M);   // Serializer tail
    do begin
      read_status(st);
      if (st[15:8] != 8'd0) begin
        wb_xfer(1'b0, `REG_DATA, 32'h0, r);
        if (r.err) begin
          errors++;
          $display("ERROR at %0t ns: data read returned err with words waiting", $time);
        end
        grp[n] = r.dat;
        n++;
        if (n == 8) begin
          check_group(grp, allow_drop);
          n = 0;
        end
      end
    end while (st[15:8] != 8'd0);
    if (n != 0) begin
      errors++;
      $display("ERROR at %0t ns: %0d words of a split beat left over", $time, n);
    end
    if (!allow_drop && exp_q.size() != 0) begin
      errors++;
      $display("ERROR at %0t ns: %0d expected beats never arrived", $time, exp_q.size());
    end
    exp_q.delete();
  endtask

  // FIFO level bound during back-pressure
  always @(posedge clk100M) begin
    if (!rst_command && dut.u_fifo.level > `FIFO_DEPTH) begin
      errors++;
      $display("ERROR at %0t ns: fifo_level got %0d expected at most %0d",
               $time, dut.u_fifo.level, `FIFO_DEPTH);
    end
  end

  initial begin
    #(WATCH_CYCLES * 10);
    $display("Watchdog expired after %0d cycles, the run did not finish", WATCH_CYCLES);
    $display("Simulation failed");
    $finish;
  end

  initial begin
    logic [31:0]     st;
    wb_rsp_t         r;
    readout_window_t win_b;
    errors = 0;
    checks = 0;
    rng    = 32'd28;
    rst_command <= 1'b1;
    wb_req      <= '0;
    beat_valid  <= 1'b0;
    beat_data   <= '0;
    frame_start <= 1'b0;
    ref_win = '{row_start: 6'd1, row_end: 6'd2, col_start: 4'd4, col_end: 4'd5};
    win_b   = '{row_start: 6'd2, row_end: 6'd3, col_start: 4'd0, col_end: 4'd1};
    repeat (5) @(posedge clk100M);
    rst_command <= 1'b0;

    // Veto and idle
    read_status(st);
    expect_val("status.veto", st[2], 1);
    expect_val("status.run_state", st[1:0], R_IDLE);
    set_window(ref_win);
    wb_write(`REG_CMD, CMD_INIT);
    read_status(st);
    expect_val("status.run_state", st[1:0], R_READY);
    wb_write(`REG_CMD, CMD_START);
    read_status(st);
    expect_val("status.veto", st[2], 1);
    expect_val("status.run_state", st[1:0], R_RUNNING);
    send_frame(1'b0);                  // Running, but the veto still blocks
    drain(1'b0);
    repeat (`VETO_CYCLES) @(posedge clk100M);

    // Window packing
    read_status(st);
    expect_val("status.veto", st[2], 0);
    expect_val("status.run_state", st[1:0], R_RUNNING);
    send_frame(1'b1);
    drain(1'b0);

    // Pending window stays parked
    set_window(win_b);
    send_frame(1'b1);
    drain(1'b0);

    // STOP inside row 0, window still completes
    read_status(st);
    expect_val("status.frame_count", st[23:16], 2);   // Two windows done so far
    fork
      send_frame(1'b1);
      begin
        repeat (12) @(posedge clk100M);
        wb_write(`REG_CMD, CMD_STOP);
      end
    join
    drain(1'b0);
    read_status(st);
    expect_val("status.frame_count", st[23:16], 3);
    expect_val("status.run_state", st[1:0], R_READY);
    send_frame(1'b0);
    drain(1'b0);

    // INIT now applies the staged window
    wb_write(`REG_CMD, CMD_INIT);
    ref_win = win_b;
    wb_write(`REG_CMD, CMD_START);
    send_frame(1'b1);
    drain(1'b0);

    // Back-pressure, nothing read until the end
    repeat (3) send_frame(1'b1);
    drain(1'b1);

    // Empty read
    wb_xfer(1'b0, `REG_DATA, 32'h0, r);
    expect_val("wb_rsp.err", r.err, 1);
    expect_val("wb_rsp.ack", r.ack, 0);

    $display("Checks run: %0d, errors: %0d", checks, errors);
    if (errors == 0) begin
      $display("Simulation passed");
    end else begin
      $display("Simulation failed");
    end
    $finish;
  end

endmodule
